// ==== src/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath width
`define XLEN 32

// 32 architectural registers
`define REG_ADDR_W 5

// Memory depths in words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

`endif

// ==== src/isa_pkg.sv ====
package isa_pkg;

    // Major opcodes handled by this core
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011; // LW
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011; // SW
    localparam logic [6:0] OPCODE_ARITH  = 7'b0010011; // Register-immediate ops
    localparam logic [6:0] OPCODE_R_TYPE = 7'b0110011; // Register-register ops
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011; // Only BEQ acted on

    // funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_NOR = 3'b100; // NOR lives in the XOR slot
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;

    // One instruction word, four ways to slice it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;      // imm[11:0]
            logic [19:0] rest;     // rs1, funct3, rd, opcode
        } i;
        struct packed {
            logic [6:0]  imm_hi;   // imm[11:5]
            logic [12:0] regs;     // rs2, rs1, funct3
            logic [4:0]  imm_lo;   // imm[4:0]
            logic [6:0]  opcode;
        } s;
        struct packed {
            logic        imm_12;
            logic [5:0]  imm_10_5;
            logic [12:0] regs;     // rs2, rs1, funct3
            logic [3:0]  imm_4_1;
            logic        imm_11;
            logic [6:0]  opcode;
        } b;
    } instr_t;

endpackage

// ==== src/core_pkg.sv ====
package core_pkg;

    // Operation class from decode
    localparam logic [1:0] ALU_OP_ADD   = 2'b00; // Address calc for LW/SW
    localparam logic [1:0] ALU_OP_SUB   = 2'b01; // Compare for BEQ
    localparam logic [1:0] ALU_OP_FUNCT = 2'b10; // Look at funct3/funct7

    // ALU function codes
    localparam logic [3:0] ALU_AND = 4'b0000;
    localparam logic [3:0] ALU_OR  = 4'b0001;
    localparam logic [3:0] ALU_ADD = 4'b0010;
    localparam logic [3:0] ALU_SUB = 4'b0110;
    localparam logic [3:0] ALU_SLT = 4'b0111; // Signed compare
    localparam logic [3:0] ALU_NOR = 4'b1100;

    // Operand source in execute
    localparam logic [1:0] FWD_REG = 2'b00; // Value carried in ID/EX
    localparam logic [1:0] FWD_WB  = 2'b01; // From MEM/WB
    localparam logic [1:0] FWD_MEM = 2'b10; // From EX/MEM

endpackage

// ==== src/register_file.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module register_file (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);
    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    // x0 never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    // Reads are combinational, x0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module fetch_stage #(
    parameter int IMEM_WORDS = `IMEM_WORDS  // Any power of two
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_we,     // Program load, during reset
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,   // Word index
    input  logic [`XLEN-1:0]              imem_wdata,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic [`XLEN-1:0]              redirect_pc,
    output logic [`XLEN-1:0]              if_pc,
    output isa_pkg::instr_t               if_instr
);
    localparam int AW = $clog2(IMEM_WORDS);

    logic [`XLEN-1:0] imem [IMEM_WORDS];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] fetch_word;

    // Load port
    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_addr] <= imem_wdata;
    end

    assign fetch_word = imem[pc[AW+1:2]]; // Combinational read, word aligned

    // Redirect beats stall beats sequential
    always_comb begin
        if (redirect)
            pc_next = redirect_pc;
        else if (stall)
            pc_next = pc;
        else
            pc_next = pc + `XLEN'd4;
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= '0;
        else
            pc <= pc_next;
    end

    // IF/ID, zero word is a no-op
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            if_instr <= '0;
        end else if (!stall) begin
            if_instr <= fetch_word;
            if_pc    <= pc;
        end
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       if_pc,
    input  isa_pkg::instr_t        if_instr,
    input  logic [`XLEN-1:0]       rs1_data,      // Register file reads
    input  logic [`XLEN-1:0]       rs2_data,
    input  logic                   ex_mem_read,   // Load sitting in execute
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic                   flush,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic                   stall,
    output logic [`XLEN-1:0]       id_ex_pc,
    output logic [`XLEN-1:0]       id_ex_rs1_data,
    output logic [`XLEN-1:0]       id_ex_rs2_data,
    output logic [`XLEN-1:0]       id_ex_imm,
    output logic [`REG_ADDR_W-1:0] id_ex_rs1,
    output logic [`REG_ADDR_W-1:0] id_ex_rs2,
    output logic [`REG_ADDR_W-1:0] id_ex_rd,
    output logic                   id_ex_alu_src,
    output logic [1:0]             id_ex_alu_op,
    output logic [2:0]             id_ex_funct3,
    output logic                   id_ex_funct7_bit5,
    output logic                   id_ex_mem_read,
    output logic                   id_ex_mem_write,
    output logic                   id_ex_branch,
    output logic                   id_ex_reg_write,
    output logic                   id_ex_mem_to_reg
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [6:0]       opcode;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             alu_src;
    logic [1:0]       alu_op;
    logic             mem_read;
    logic             mem_write;
    logic             branch;
    logic             reg_write;
    logic             mem_to_reg;

    assign opcode   = if_instr.r.opcode;
    assign rs1_addr = if_instr.r.rs1;
    assign rs2_addr = if_instr.r.rs2;

    // Immediate, format picked by opcode
    always_comb begin
        case (opcode)
            OPCODE_LOAD, OPCODE_ARITH:
                imm = {{(`XLEN-12){if_instr.i.imm[11]}}, if_instr.i.imm};
            OPCODE_STORE:
                imm = {{(`XLEN-12){if_instr.s.imm_hi[6]}}, if_instr.s.imm_hi,
                       if_instr.s.imm_lo};
            OPCODE_BRANCH:
                imm = {{(`XLEN-12){if_instr.b.imm_12}}, if_instr.b.imm_11,
                       if_instr.b.imm_10_5, if_instr.b.imm_4_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    // Main control, unknown opcodes fall through as no-ops
    always_comb begin
        alu_src    = 1'b0;
        alu_op     = ALU_OP_ADD;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        case (opcode)
            OPCODE_LOAD: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            OPCODE_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OPCODE_ARITH: begin
                alu_src   = 1'b1;
                alu_op    = ALU_OP_FUNCT;
                reg_write = 1'b1;
            end
            OPCODE_R_TYPE: begin
                alu_op    = ALU_OP_FUNCT;
                reg_write = 1'b1;
            end
            OPCODE_BRANCH: begin
                alu_op = ALU_OP_SUB;                        // Zero flag means equal
                branch = (if_instr.r.funct3 == F3_BEQ);     // Other conditions ignored
            end
            default: ;
        endcase
    end

    // Load-use hazard
    assign stall = ex_mem_read && (ex_rd != '0) &&
                   ((ex_rd == rs1_addr) || (ex_rd == rs2_addr));

    // Write-through from writeback, wb_valid already excludes x0
    assign rs1_val = (wb_valid && wb_rd == rs1_addr) ? wb_data : rs1_data;
    assign rs2_val = (wb_valid && wb_rd == rs2_addr) ? wb_data : rs2_data;

    always_ff @(posedge clk) begin
        if (reset || stall || flush) begin
            id_ex_mem_read   <= 1'b0;   // Bubble
            id_ex_mem_write  <= 1'b0;
            id_ex_branch     <= 1'b0;
            id_ex_reg_write  <= 1'b0;
            id_ex_mem_to_reg <= 1'b0;
        end else begin
            id_ex_mem_read   <= mem_read;
            id_ex_mem_write  <= mem_write;
            id_ex_branch     <= branch;
            id_ex_reg_write  <= reg_write;
            id_ex_mem_to_reg <= mem_to_reg;
        end
        id_ex_pc          <= if_pc;
        id_ex_rs1_data    <= rs1_val;
        id_ex_rs2_data    <= rs2_val;
        id_ex_imm         <= imm;
        id_ex_rs1         <= rs1_addr;
        id_ex_rs2         <= rs2_addr;
        id_ex_rd          <= if_instr.r.rd;
        id_ex_alu_src     <= alu_src;
        id_ex_alu_op      <= alu_op;
        id_ex_funct3      <= if_instr.r.funct3;
        id_ex_funct7_bit5 <= if_instr.r.funct7[5];  // SUB select
    end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic [`XLEN-1:0]       id_ex_pc,
    input  logic [`XLEN-1:0]       id_ex_rs1_data,
    input  logic [`XLEN-1:0]       id_ex_rs2_data,
    input  logic [`XLEN-1:0]       id_ex_imm,
    input  logic [`REG_ADDR_W-1:0] id_ex_rs1,
    input  logic [`REG_ADDR_W-1:0] id_ex_rs2,
    input  logic [`REG_ADDR_W-1:0] id_ex_rd,
    input  logic                   id_ex_alu_src,
    input  logic [1:0]             id_ex_alu_op,
    input  logic [2:0]             id_ex_funct3,
    input  logic                   id_ex_funct7_bit5,
    input  logic                   id_ex_mem_read,
    input  logic                   id_ex_mem_write,
    input  logic                   id_ex_branch,
    input  logic                   id_ex_reg_write,
    input  logic                   id_ex_mem_to_reg,
    input  logic                   mem_fwd_we,      // EX/MEM result with nonzero rd
    input  logic [`REG_ADDR_W-1:0] mem_fwd_rd,
    input  logic [`XLEN-1:0]       mem_fwd_data,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   ex_mem_read,     // To decode stall check
    output logic [`REG_ADDR_W-1:0] ex_rd,
    output logic [`XLEN-1:0]       ex_mem_alu_result,
    output logic [`XLEN-1:0]       ex_mem_store_data,
    output logic                   ex_mem_zero,
    output logic [`XLEN-1:0]       ex_mem_branch_target,
    output logic [`REG_ADDR_W-1:0] ex_mem_rd,
    output logic                   ex_mem_branch,
    output logic                   ex_mem_mem_read,
    output logic                   ex_mem_mem_write,
    output logic                   ex_mem_reg_write,
    output logic                   ex_mem_mem_to_reg
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [1:0]       fwd_a;
    logic [1:0]       fwd_b;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;     // Also the store data
    logic [`XLEN-1:0] op_b;
    logic [3:0]       alu_ctrl;
    logic [`XLEN-1:0] alu_result;

    // EX/MEM has priority over MEM/WB
    function automatic logic [1:0] fwd_select(input logic [`REG_ADDR_W-1:0] rs);
        if (mem_fwd_we && mem_fwd_rd == rs)
            return FWD_MEM;
        if (wb_valid && wb_rd == rs)
            return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a = fwd_select(id_ex_rs1);
        fwd_b = fwd_select(id_ex_rs2);
    end

    assign op_a    = (fwd_a == FWD_MEM) ? mem_fwd_data :
                     (fwd_a == FWD_WB)  ? wb_data : id_ex_rs1_data;
    assign rs2_fwd = (fwd_b == FWD_MEM) ? mem_fwd_data :
                     (fwd_b == FWD_WB)  ? wb_data : id_ex_rs2_data;
    assign op_b    = id_ex_alu_src ? id_ex_imm : rs2_fwd;

    // ALU control
    always_comb begin
        alu_ctrl = ALU_ADD;
        case (id_ex_alu_op)
            ALU_OP_SUB: alu_ctrl = ALU_SUB;
            ALU_OP_FUNCT: begin
                case (id_ex_funct3)
                    F3_ADD: alu_ctrl = (id_ex_funct7_bit5 && !id_ex_alu_src) ?
                                       ALU_SUB : ALU_ADD;   // ADDI never subtracts
                    F3_AND: alu_ctrl = ALU_AND;
                    F3_OR:  alu_ctrl = ALU_OR;
                    F3_SLT: alu_ctrl = ALU_SLT;
                    F3_NOR: alu_ctrl = ALU_NOR;
                    default: alu_ctrl = ALU_AND;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        case (alu_ctrl)
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_NOR: alu_result = ~(op_a | op_b);
            default: alu_result = op_a + op_b;
        endcase
    end

    assign ex_mem_read = id_ex_mem_read;
    assign ex_rd       = id_ex_rd;

    // EX/MEM also squashes the instruction behind a taken branch
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ex_mem_branch     <= 1'b0;
            ex_mem_mem_read   <= 1'b0;
            ex_mem_mem_write  <= 1'b0;
            ex_mem_reg_write  <= 1'b0;
            ex_mem_mem_to_reg <= 1'b0;
        end else begin
            ex_mem_branch     <= id_ex_branch;
            ex_mem_mem_read   <= id_ex_mem_read;
            ex_mem_mem_write  <= id_ex_mem_write;
            ex_mem_reg_write  <= id_ex_reg_write;
            ex_mem_mem_to_reg <= id_ex_mem_to_reg;
        end
        ex_mem_alu_result    <= alu_result;
        ex_mem_store_data    <= rs2_fwd;
        ex_mem_zero          <= (alu_result == '0);
        ex_mem_branch_target <= id_ex_pc + id_ex_imm;  // PC-relative target
        ex_mem_rd            <= id_ex_rd;
    end

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module memory_stage #(
    parameter int DMEM_WORDS = `DMEM_WORDS  // Any power of two
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       ex_mem_alu_result,
    input  logic [`XLEN-1:0]       ex_mem_store_data,
    input  logic                   ex_mem_zero,
    input  logic [`XLEN-1:0]       ex_mem_branch_target,
    input  logic [`REG_ADDR_W-1:0] ex_mem_rd,
    input  logic                   ex_mem_branch,
    input  logic                   ex_mem_mem_read,
    input  logic                   ex_mem_mem_write,
    input  logic                   ex_mem_reg_write,
    input  logic                   ex_mem_mem_to_reg,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirect_pc,
    output logic                   mem_fwd_we,
    output logic [`REG_ADDR_W-1:0] mem_fwd_rd,
    output logic [`XLEN-1:0]       mem_fwd_data,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);
    localparam int AW = $clog2(DMEM_WORDS);

    logic [`XLEN-1:0] dmem [DMEM_WORDS];
    logic [AW-1:0]    dmem_idx;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] mem_wb_alu_result;
    logic [`XLEN-1:0] mem_wb_load_data;
    logic             mem_wb_mem_to_reg;

    assign dmem_idx = ex_mem_alu_result[AW+1:2];   // Word aligned only

    always_ff @(posedge clk) begin
        if (ex_mem_mem_write)
            dmem[dmem_idx] <= ex_mem_store_data;
    end

    assign load_data = ex_mem_mem_read ? dmem[dmem_idx] : '0;

    // BEQ resolves here, predicted not taken
    assign redirect    = ex_mem_branch && ex_mem_zero;
    assign redirect_pc = ex_mem_branch_target;

    // Forward path into execute
    assign mem_fwd_we   = ex_mem_reg_write && (ex_mem_rd != '0);
    assign mem_fwd_rd   = ex_mem_rd;
    assign mem_fwd_data = ex_mem_alu_result;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_fwd_we;    // Only nonzero rd retires visibly
        wb_rd             <= ex_mem_rd;
        mem_wb_alu_result <= ex_mem_alu_result;
        mem_wb_load_data  <= load_data;
        mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
    end

    assign wb_data = mem_wb_mem_to_reg ? mem_wb_load_data : mem_wb_alu_result;

endmodule

// ==== src/cpu_pipelined.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module cpu_pipelined (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           imem_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imem_addr,
    input  logic [`XLEN-1:0]               imem_wdata,
    output logic                           wb_valid,  // Retire strobe
    output logic [`REG_ADDR_W-1:0]         wb_rd,
    output logic [`XLEN-1:0]               wb_data
);
    import isa_pkg::*;

    // IF/ID and hazard
    logic [`XLEN-1:0]       if_pc;
    instr_t                 if_instr;
    logic                   stall;
    // Register file read side
    logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [`XLEN-1:0]       rs1_data, rs2_data;
    // ID/EX
    logic [`XLEN-1:0]       id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    logic [`REG_ADDR_W-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
    logic [1:0]             id_ex_alu_op;
    logic [2:0]             id_ex_funct3;
    logic                   id_ex_alu_src, id_ex_funct7_bit5;
    logic                   id_ex_mem_read, id_ex_mem_write, id_ex_branch;
    logic                   id_ex_reg_write, id_ex_mem_to_reg;
    // Load in execute, for the stall check
    logic                   ex_mem_read;
    logic [`REG_ADDR_W-1:0] ex_rd;
    // EX/MEM
    logic [`XLEN-1:0]       ex_mem_alu_result, ex_mem_store_data, ex_mem_branch_target;
    logic [`REG_ADDR_W-1:0] ex_mem_rd;
    logic                   ex_mem_zero, ex_mem_branch, ex_mem_mem_read;
    logic                   ex_mem_mem_write, ex_mem_reg_write, ex_mem_mem_to_reg;
    // Memory stage back to earlier stages
    logic                   redirect;     // Taken BEQ, doubles as flush
    logic [`XLEN-1:0]       redirect_pc;
    logic                   mem_fwd_we;
    logic [`REG_ADDR_W-1:0] mem_fwd_rd;
    logic [`XLEN-1:0]       mem_fwd_data;

    fetch_stage #(.IMEM_WORDS(`IMEM_WORDS)) i_fetch_stage (.*);

    decode_stage i_decode_stage (.flush(redirect), .*);

    register_file i_register_file (
        .clk    (clk),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .we     (wb_valid),   // Same strobe the trace port shows
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_stage i_execute_stage (.flush(redirect), .*);

    memory_stage #(.DMEM_WORDS(`DMEM_WORDS)) i_memory_stage (.*);

endmodule

// ==== tests/cpu_properties.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module cpu_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   redirect,   // Taken BEQ from memory stage
    input logic                   stall,
    input logic                   wb_valid,
    input logic [`REG_ADDR_W-1:0] wb_rd
);

    // Branch state cleared by reset
    property no_redirect_after_reset;
        @(posedge clk) reset |=> !redirect;
    endproperty

    // Bubble in ID/EX removes the load, so one cycle only
    property stall_single_cycle;
        @(posedge clk) disable iff (reset) stall |=> !stall;
    endproperty

    property no_x0_retire;
        @(posedge clk) disable iff (reset) wb_valid |-> (wb_rd != '0);
    endproperty

    assert property (no_redirect_after_reset)
        else $error("redirect high in the cycle after reset");
    assert property (stall_single_cycle)
        else $error("load-use stall held for two cycles");
    assert property (no_x0_retire)
        else $error("writeback strobe with rd of x0");

endmodule

// Decode sees stall, flush and the writeback triple from memory
bind decode_stage cpu_properties i_cpu_properties (
    .clk      (clk),
    .reset    (reset),
    .redirect (flush),
    .stall    (stall),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd)
);

// ==== tests/tb_cpu.sv ====
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;
endmodule

module tb_cpu;
    localparam int NUM_TESTS      = 5;
    localparam int PROG_WORDS     = 12;    // Rest of memory loaded with zero
    localparam int MAX_WB         = 12;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int QUIET_CYCLES   = 20;    // Short of the PC wrapping back to 0
    localparam int RESET_CYCLES   = 4;
    localparam int IMEM_AW        = $clog2(`IMEM_WORDS);
    localparam int OP_IMM         = 'h13;
    localparam int OP_LOAD        = 'h03;

    logic                   clk;
    logic                   reset;
    logic                   imem_we;
    logic [IMEM_AW-1:0]     imem_addr;
    logic [`XLEN-1:0]       imem_wdata;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    // Test table
    string                  test_name [NUM_TESTS];
    logic [`XLEN-1:0]       prog      [NUM_TESTS][PROG_WORDS];
    int                     exp_count [NUM_TESTS];
    logic [`REG_ADDR_W-1:0] exp_rd    [NUM_TESTS][MAX_WB];
    logic [`XLEN-1:0]       exp_val   [NUM_TESTS][MAX_WB];
    int                     cur_test;
    int                     cur_word;
    int                     total_checks;
    int                     total_errors;
    int                     tests_ok;

    tb_clock #(.PERIOD_NS(20)) i_tb_clock (.clk(clk));

    cpu_pipelined i_cpu_pipelined (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // RV32I encoders
    function automatic logic [31:0] r_word(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input int opcode, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opcode[6:0]};
    endfunction

    function automatic logic [31:0] s_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
                7'b1100011};
    endfunction

    task automatic begin_test(input string name);
        cur_test = cur_test + 1;
        cur_word = 0;
        test_name[cur_test] = name;
        exp_count[cur_test] = 0;
    endtask

    task automatic put_instr(input logic [31:0] word);
        prog[cur_test][cur_word] = word;
        cur_word = cur_word + 1;
    endtask

    task automatic expect_wb(input int rd, input logic [31:0] value);
        exp_rd[cur_test][exp_count[cur_test]]  = rd[4:0];
        exp_val[cur_test][exp_count[cur_test]] = value;
        exp_count[cur_test] = exp_count[cur_test] + 1;
    endtask

    task automatic build_table();
        foreach (prog[t, w])
            prog[t][w] = '0;
        cur_test = -1;
        begin_test("arithmetic with gaps");
        put_instr(i_word(OP_IMM, 0, 1, 0, 12));         // addi x1, x0, 12
        put_instr(i_word(OP_IMM, 0, 2, 0, -7));         // addi x2, x0, -7
        put_instr(32'h0);
        put_instr(32'h0);                               // x2 reaches add by write-through
        put_instr(r_word(0, 0, 3, 1, 2));               // add x3, x1, x2
        put_instr(r_word('h20, 0, 4, 1, 2));            // sub x4, x1, x2
        put_instr(r_word(0, 7, 5, 1, 2));               // and
        put_instr(r_word(0, 6, 6, 1, 2));               // or
        put_instr(r_word(0, 2, 7, 2, 1));               // slt x7, x2, x1
        put_instr(r_word(0, 2, 8, 1, 2));               // slt x8, x1, x2
        put_instr(r_word(0, 4, 9, 1, 2));               // nor
        put_instr(i_word(OP_IMM, 0, 10, 1, 'h400));     // addi with imm bit 10 set
        expect_wb(1, 12);
        expect_wb(2, 32'hFFFF_FFF9);
        expect_wb(3, 5);
        expect_wb(4, 19);
        expect_wb(5, 8);
        expect_wb(6, 32'hFFFF_FFFD);
        expect_wb(7, 1);                                // -7 < 12 signed
        expect_wb(8, 0);
        expect_wb(9, 2);
        expect_wb(10, 1036);
        begin_test("back-to-back forwarding");
        put_instr(i_word(OP_IMM, 0, 1, 0, 5));
        put_instr(i_word(OP_IMM, 0, 2, 1, 3));          // x1 from EX/MEM
        put_instr(r_word(0, 0, 3, 1, 2));               // x2 EX/MEM, x1 MEM/WB
        put_instr(r_word('h20, 0, 4, 3, 1));
        put_instr(s_word(4, 0, 0));                     // sw x4, 0(x0) with data from EX/MEM
        put_instr(s_word(4, 0, 4));                     // Data from MEM/WB
        put_instr(i_word(OP_LOAD, 2, 5, 0, 0));
        put_instr(i_word(OP_LOAD, 2, 6, 0, 4));
        put_instr(r_word(0, 0, 7, 5, 6));               // Load-use on x6
        expect_wb(1, 5);
        expect_wb(2, 8);
        expect_wb(3, 13);
        expect_wb(4, 8);
        expect_wb(5, 8);
        expect_wb(6, 8);                                // Stale x4 would give 19
        expect_wb(7, 16);
        begin_test("store, load and load-use stall");
        put_instr(i_word(OP_IMM, 0, 1, 0, 85));
        put_instr(i_word(OP_IMM, 0, 2, 0, 16));
        put_instr(s_word(1, 2, 0));                     // sw x1, 0(x2)
        put_instr(i_word(OP_LOAD, 2, 3, 2, 0));
        put_instr(r_word(0, 0, 4, 3, 1));               // Needs the stall
        put_instr(i_word(OP_LOAD, 2, 5, 2, 0));
        put_instr(32'h0);
        put_instr(r_word(0, 0, 6, 5, 5));               // Load data from MEM/WB
        expect_wb(1, 85);
        expect_wb(2, 16);
        expect_wb(3, 85);
        expect_wb(4, 170);
        expect_wb(5, 85);
        expect_wb(6, 170);
        begin_test("taken and not-taken BEQ");
        put_instr(i_word(OP_IMM, 0, 1, 0, 3));
        put_instr(i_word(OP_IMM, 0, 2, 0, 3));
        put_instr(b_word(1, 2, 16));                    // Taken to word 6
        put_instr(i_word(OP_IMM, 0, 3, 0, 1));          // Three squashed
        put_instr(i_word(OP_IMM, 0, 4, 0, 2));
        put_instr(i_word(OP_IMM, 0, 5, 0, 3));
        put_instr(i_word(OP_IMM, 0, 6, 0, 4));
        put_instr(b_word(1, 6, 8));                     // 3 != 4 so it falls through
        put_instr(i_word(OP_IMM, 0, 7, 0, 5));
        put_instr(i_word(OP_IMM, 0, 8, 0, 6));
        expect_wb(1, 3);
        expect_wb(2, 3);
        expect_wb(6, 4);
        expect_wb(7, 5);
        expect_wb(8, 6);
        begin_test("x0 writes and reset");
        put_instr(i_word(OP_IMM, 0, 0, 0, 99));         // Writes x0 without an event
        put_instr(r_word(0, 0, 0, 1, 1));
        put_instr(r_word(0, 0, 1, 0, 0));               // add x1, x0, x0
        put_instr(i_word(OP_IMM, 0, 2, 0, 7));
        put_instr(r_word(0, 6, 3, 0, 2));               // or x3, x0, x2
        expect_wb(1, 0);
        expect_wb(2, 7);
        expect_wb(3, 7);
    endtask

    task automatic run_test(input int t);
        int errors;
        int cycles;
        bit timed_out;
        errors    = 0;
        timed_out = 0;
        @(posedge clk);
        #2;
        reset = 1'b1;
        // Whole memory rewritten with no-op padding
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            imem_we    = 1'b1;
            imem_addr  = IMEM_AW'(i);
            imem_wdata = (i < PROG_WORDS) ? prog[t][i] : '0;
            @(posedge clk);
            #2;
        end
        imem_we = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        total_checks = total_checks + 1;
        assert (!wb_valid) else begin
            $display("CHECK FAILED at %0t: wb_valid high during reset in %s",
                     $time, test_name[t]);
            errors = errors + 1;
        end
        @(posedge clk);
        #2;
        reset = 1'b0;
        // Retired writes in program order
        for (int k = 0; k < exp_count[t] && !timed_out; k++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles = cycles + 1;
            end while (!wb_valid && cycles < TIMEOUT_CYCLES);
            if (!wb_valid) begin
                $display("Timeout: writeback %0d of %s did not arrive within %0d cycles",
                         k, test_name[t], TIMEOUT_CYCLES);
                errors    = errors + 1;
                timed_out = 1;
            end else begin
                total_checks = total_checks + 1;
                assert (wb_rd === exp_rd[t][k] && wb_data === exp_val[t][k]) else begin
                    $display("CHECK FAILED at %0t: %s writeback %0d expected x%0d=%h, got x%0d=%h",
                             $time, test_name[t], k, exp_rd[t][k], exp_val[t][k],
                             wb_rd, wb_data);
                    errors = errors + 1;
                end
            end
        end
        // Squashed or x0 writes must stay invisible
        if (!timed_out) begin
            total_checks = total_checks + 1;
            for (int c = 0; c < QUIET_CYCLES; c++) begin
                @(negedge clk);
                assert (!wb_valid) else begin
                    $display("CHECK FAILED at %0t: %s extra writeback x%0d=%h",
                             $time, test_name[t], wb_rd, wb_data);
                    errors = errors + 1;
                end
            end
        end
        total_errors = total_errors + errors;
        if (errors == 0) begin
            tests_ok = tests_ok + 1;
            $display("Test %0d %s: ok", t, test_name[t]);
        end else begin
            $display("Test %0d %s: %0d errors", t, test_name[t], errors);
        end
    endtask

    initial begin
        reset        = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        total_checks = 0;
        total_errors = 0;
        tests_ok     = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("%0d of %0d tests ok, %0d checks, %0d errors",
                 tests_ok, NUM_TESTS, total_checks, total_errors);
        if (total_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+src
src/isa_pkg.sv
src/core_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_pipelined.sv
tests/cpu_properties.sv
tests/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the pipelined core testbench with Verilator

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --assert --timing -f tb.f --top-module tb_cpu \
    -Mdir "$OBJ_DIR" -o Vtb_cpu
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_cpu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
